// ==== Makefile ====
TOP := icache_tb
BUILD := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f verilog.f -Mdir $(BUILD) -o $(TOP)

run: build
	./$(BUILD)/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "No errors" sim.log || (echo "Simulation ended early"; exit 1)

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf $(BUILD) sim.log

// ==== bench/icache_chk.sv ====
// Instruction cache protocol checker
`timescale 1ns/10ps

module icache_chk import icache_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic resp_valid_i,
  input  logic resp_fault_i,
  input  logic flush_done_i,
  input  logic mem_req_valid_i,
  input  logic mem_beat_valid_i
);

  localparam logic [BeatsWidth:0] BeatsPerLine = {1'b1, {BeatsWidth{1'b0}}};

  // Beats still owed by memory for the open line request
  logic [BeatsWidth:0] beats_left_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beats_left_q <= '0;
    end else if (mem_req_valid_i) begin
      beats_left_q <= BeatsPerLine;
    end else if (mem_beat_valid_i && beats_left_q != '0) begin
      beats_left_q <= beats_left_q - 1'b1;
    end
  end

  fault_with_resp_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_fault_i |-> resp_valid_i)
    else $error("Fault flag raised without a response strobe");

  resp_or_flush_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(resp_valid_i && flush_done_i))
    else $error("Response and flush done in the same cycle");

  one_line_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_i |-> beats_left_q == '0)
    else $error("New line request before eight beats arrived");

endmodule

bind icache_top icache_chk i_icache_chk (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .resp_valid_i     (resp_valid_o),
  .resp_fault_i     (resp_fault_o),
  .flush_done_i     (flush_done_o),
  .mem_req_valid_i  (mem_req_valid_o),
  .mem_beat_valid_i (mem_beat_valid_i)
);

// ==== bench/icache_tb.sv ====
// Instruction cache testbench
`timescale 1ns/10ps

module icache_tb;

  // Test table layout, five words per row
  localparam int MaxRows = 64;
  localparam int RowWords = 5;
  localparam int TableWords = MaxRows * RowWords;
  localparam logic [31:0] WordMask = 32'h5a5a0000;

  logic        clk_i;
  logic        rst_ni;
  logic        req_valid_i;
  logic        req_flush_i;
  logic [31:0] req_addr_i;
  logic        resp_valid_o;
  logic [31:0] resp_instr_o;
  logic        resp_fault_o;
  logic        flush_done_o;
  logic        mem_req_valid_o;
  logic [31:0] mem_req_addr_o;
  logic        mem_beat_valid_i;
  logic [63:0] mem_beat_data_i;
  logic        mem_beat_denied_i;

  logic [31:0] table_mem [TableWords];
  int          num_rows = 0;
  logic        rows_loaded = 1'b0;
  int          cycle_cnt = 0;
  int          mem_req_cnt = 0;
  logic        line_denied = 1'b0;
  logic [31:0] fetch_line = '0;
  logic [31:0] rng_q = 32'hf1aa;
  logic        pass_seen = 1'b0;
  logic        fail_seen = 1'b0;

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Edge counter, read only away from the rising edge
  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  icache_top i_icache_top (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_valid_i       (req_valid_i),
    .req_flush_i       (req_flush_i),
    .req_addr_i        (req_addr_i),
    .resp_valid_o      (resp_valid_o),
    .resp_instr_o      (resp_instr_o),
    .resp_fault_o      (resp_fault_o),
    .flush_done_o      (flush_done_o),
    .mem_req_valid_o   (mem_req_valid_o),
    .mem_req_addr_o    (mem_req_addr_o),
    .mem_beat_valid_i  (mem_beat_valid_i),
    .mem_beat_data_i   (mem_beat_data_i),
    .mem_beat_denied_i (mem_beat_denied_i)
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Memory contents follow the address
  function automatic logic [31:0] instr_at(input logic [31:0] addr);
    return addr ^ WordMask;
  endfunction

  task automatic announce_failure();
    if (!fail_seen) begin
      fail_seen = 1'b1;
      $display("Errors found");
    end
  endtask

  task automatic report_error(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    announce_failure();
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic wait_flush_done();
    @(negedge clk_i);
    while (!flush_done_o) begin
      @(negedge clk_i);
    end
  endtask

  ////////////////////
  // Memory model
  ////////////////////

  always begin
    logic [31:0] line_addr;
    logic [31:0] beat_addr;
    int          gap;
    @(negedge clk_i);
    if (mem_req_valid_o) begin
      assert (mem_req_addr_o == fetch_line) else
        report_error($sformatf("line request at %h, expected %h",
                               mem_req_addr_o, fetch_line));
      line_addr = mem_req_addr_o;
      mem_req_cnt = mem_req_cnt + 1;
      @(posedge clk_i);
      #1;
      for (int b = 0; b < 8; b++) begin
        rng_q = xorshift32(rng_q);
        gap = int'(rng_q % 32'd3);
        repeat (gap) begin
          @(posedge clk_i);
          #1;
        end
        beat_addr = line_addr + 32'(b * 8);
        mem_beat_valid_i = 1'b1;
        mem_beat_data_i = {instr_at(beat_addr + 32'd4), instr_at(beat_addr)};
        mem_beat_denied_i = line_denied;
        @(posedge clk_i);
        #1;
        mem_beat_valid_i = 1'b0;
        mem_beat_denied_i = 1'b0;
      end
    end
  end

  ////////////////////
  // Operations
  ////////////////////

  task automatic run_fetch(input logic [31:0] addr, input logic deny,
                           input logic exp_miss, input logic exp_fault);
    int req_cycle;
    int resp_cycle;
    int req_before;
    int mem_reqs;
    @(posedge clk_i);
    #1;
    line_denied = deny;
    fetch_line = {addr[31:6], 6'b0};
    req_valid_i = 1'b1;
    req_flush_i = 1'b0;
    req_addr_i = addr;
    req_cycle = cycle_cnt + 1;
    req_before = mem_req_cnt;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    @(negedge clk_i);
    while (!resp_valid_o) begin
      @(negedge clk_i);
    end
    // The response strobe is sampled at the next rising edge
    resp_cycle = cycle_cnt + 1;
    mem_reqs = mem_req_cnt - req_before;
    assert (mem_reqs == (exp_miss ? 1 : 0)) else
      report_error($sformatf("fetch %h made %0d line requests, expected miss %0b",
                             addr, mem_reqs, exp_miss));
    assert (resp_fault_o == exp_fault) else
      report_error($sformatf("fetch %h fault %0b, expected %0b", addr, resp_fault_o, exp_fault));
    if (!exp_fault) begin
      assert (resp_instr_o == instr_at(addr)) else
        report_error($sformatf("fetch %h returned %h, expected %h",
                               addr, resp_instr_o, instr_at(addr)));
    end
    if (!exp_miss) begin
      assert (resp_cycle - req_cycle == 2) else
        report_error($sformatf("hit at %h answered after %0d cycles, expected 2",
                               addr, resp_cycle - req_cycle));
    end
  endtask

  task automatic run_flush();
    int req_cycle;
    int req_before;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b1;
    req_flush_i = 1'b1;
    req_addr_i = '0;
    req_cycle = cycle_cnt + 1;
    req_before = mem_req_cnt;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    req_flush_i = 1'b0;
    wait_flush_done();
    assert (cycle_cnt - req_cycle == 64) else
      report_error($sformatf("flush took %0d cycles, expected 64", cycle_cnt - req_cycle));
    assert (mem_req_cnt == req_before) else
      report_error("a flush issued a memory request");
    @(negedge clk_i);
    assert (!flush_done_o) else
      report_error("flush done stayed high for more than one cycle");
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    wait (rows_loaded);
    repeat (num_rows * 200 + 100) @(posedge clk_i);
    $display("Timeout: the cache did not finish the test table in time");
    announce_failure();
    $fatal(1, "Watchdog expired");
  end

  // A run that stops before the last row has failed
  final begin
    if (!pass_seen) begin
      announce_failure();
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    logic [31:0] op;
    logic [31:0] addr;
    int          base;
    rst_ni = 1'b0;
    req_valid_i = 1'b0;
    req_flush_i = 1'b0;
    req_addr_i = '0;
    mem_beat_valid_i = 1'b0;
    mem_beat_data_i = '0;
    mem_beat_denied_i = 1'b0;

    // Fill never matches a fetch or flush opcode
    for (int i = 0; i < TableWords; i++) begin
      table_mem[i] = 32'hee000000 ^ 32'(i);
    end
    $readmemh("bench/icache_testdata.txt", table_mem);
    while (num_rows < MaxRows &&
           (table_mem[num_rows * RowWords] == 32'h0 ||
            table_mem[num_rows * RowWords] == 32'h1)) begin
      num_rows++;
    end
    rows_loaded = 1'b1;
    assert (num_rows > 0) else
      report_error("test table is empty or could not be read");

    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!resp_valid_o && !flush_done_o && !mem_req_valid_o) else
      report_error("outputs not idle after reset");

    // Reset sweep must finish before the first request
    wait_flush_done();

    for (int r = 0; r < num_rows; r++) begin
      base = r * RowWords;
      op = table_mem[base];
      addr = table_mem[base + 1];
      if (op == 32'h1) begin
        run_flush();
      end else begin
        run_fetch(addr, table_mem[base + 2][0], table_mem[base + 3][0],
                  table_mem[base + 4][0]);
      end
    end

    pass_seen = 1'b1;
    $display("No errors");
    $finish;
  end

endmodule

// ==== bench/icache_testdata.txt ====
// Columns: op addr deny expected_miss expected_fault
// op 0 is a fetch, 1 is a flush, f ends the table
// First touches of set 0 and set 1, then hits on both word halves
0 00001000 0 1 0
0 00001004 0 0 0
0 00001000 0 0 0
0 00001038 0 0 0
0 0000103c 0 0 0
0 00002040 0 1 0
0 00002044 0 0 0
0 0000207c 0 0 0
// Denied line faults, then the same line misses again and loads
0 00003080 1 1 1
0 00003084 0 1 0
0 000030b8 0 0 0
// Set 5 fills ways 0 to 3 by lowest invalid way
0 00010140 0 1 0
0 00011140 0 1 0
0 00012140 0 1 0
0 00013140 0 1 0
// Round robin is at way 0 here and evicts tag 10
0 00014140 0 1 0
// Sixth fetch misses and evicts way 1
0 00010144 0 1 0
0 00014148 0 0 0
0 00012144 0 0 0
0 00013178 0 0 0
// Round robin now at way 2
0 00011140 0 1 0
0 00001004 0 0 0
// Flush drops every line
1 00000000 0 0 0
0 00001004 0 1 0
0 00002040 0 1 0
0 00002044 0 0 0
0 00014140 0 1 0
// Last set, last beat
0 00005ff8 0 1 0
0 00005ffc 0 0 0
f 00000000 0 0 0

// ==== hdl/icache_fetch_ctrl.sv ====
// Instruction cache fetch front end
`timescale 1ns/10ps

module icache_fetch_ctrl import icache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     req_valid_i,
  input  logic     req_flush_i,
  input  paddr_t   req_addr_i,

  input  logic     hit_i,
  input  beat_t    hit_beat_i,
  input  way_idx_t victim_way_i,
  input  logic     sweep_done_i,
  input  logic     fill_done_i,
  input  logic     fill_denied_i,

  output logic     resp_valid_o,
  output instr_t   resp_instr_o,
  output logic     resp_fault_o,
  output logic     flush_done_o,

  output logic     lookup_o,
  output paddr_t   lookup_addr_o,
  output logic     sweep_start_o,
  output logic     fill_start_o,
  output paddr_t   fill_addr_o,
  output way_idx_t fill_way_o,
  output logic     mem_req_valid_o,
  output paddr_t   mem_req_addr_o
);

  fetch_state_e state_q;
  fetch_state_e state_d;

  paddr_t   addr_q;
  way_idx_t way_q;
  instr_t   resp_instr_q;
  logic     resp_valid_q;
  logic     fill_pulse_q;

  logic     capture_req;
  logic     hit_resp;
  logic     miss_fill;
  paddr_t   line_addr;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    lookup_o = 1'b0;
    lookup_addr_o = addr_q;
    sweep_start_o = 1'b0;
    flush_done_o = 1'b0;
    capture_req = 1'b0;
    hit_resp = 1'b0;
    miss_fill = 1'b0;

    unique case (state_q)
      FetchIdle: begin
        if (req_valid_i && req_flush_i) begin
          sweep_start_o = 1'b1;
          state_d = FetchFlush;
        end else if (req_valid_i) begin
          // Tag and data read straight from the request address
          capture_req = 1'b1;
          lookup_o = 1'b1;
          lookup_addr_o = req_addr_i;
          state_d = FetchLookup;
        end
      end

      // A replay that misses just refills again
      FetchLookup, FetchReplay: begin
        if (hit_i) begin
          hit_resp = 1'b1;
          state_d = FetchIdle;
        end else begin
          miss_fill = 1'b1;
          state_d = FetchFill;
        end
      end

      FetchFill: begin
        if (fill_done_i && fill_denied_i) begin
          state_d = FetchFault;
        end else if (fill_done_i) begin
          lookup_o = 1'b1;
          state_d = FetchReplay;
        end
      end

      // Fault response is shown for this one cycle
      FetchFault: begin
        state_d = FetchIdle;
      end

      FetchFlush: begin
        if (sweep_done_i) begin
          flush_done_o = 1'b1;
          state_d = FetchIdle;
        end
      end

      default: begin
        state_d = FetchIdle;
      end
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  // Reset sweep runs first, so the machine starts in Flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FetchFlush;
      resp_valid_q <= 1'b0;
      fill_pulse_q <= 1'b0;
    end else begin
      state_q <= state_d;
      resp_valid_q <= hit_resp;
      fill_pulse_q <= miss_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_req) begin
      addr_q <= req_addr_i;
    end
    if (miss_fill) begin
      way_q <= victim_way_i;
    end
    if (hit_resp) begin
      // Bit 2 picks the upper word of the beat
      resp_instr_q <= addr_q[2] ? hit_beat_i[63:32] : hit_beat_i[31:0];
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign line_addr = {addr_q[PaddrLen-1:LineOffsetWidth], {LineOffsetWidth{1'b0}}};

  assign resp_fault_o = state_q == FetchFault;
  assign resp_valid_o = resp_valid_q || resp_fault_o;
  assign resp_instr_o = resp_instr_q;

  // One strobe starts both the memory request and the refill engine
  assign mem_req_valid_o = fill_pulse_q;
  assign mem_req_addr_o = line_addr;
  assign fill_start_o = fill_pulse_q;
  assign fill_addr_o = line_addr;
  assign fill_way_o = way_q;

endmodule

// ==== hdl/icache_line_store.sv ====
// Instruction cache line store
`timescale 1ns/10ps

module icache_line_store import icache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      lookup_i,
  input  paddr_t    lookup_addr_i,
  input  logic      sweep_start_i,

  input  logic      wr_beat_en_i,
  input  logic      wr_tag_en_i,
  input  way_idx_t  wr_way_i,
  input  set_idx_t  wr_set_i,
  input  beat_idx_t wr_beat_idx_i,
  input  beat_t     wr_beat_i,
  input  tag_t      wr_tag_i,

  output logic      hit_o,
  output beat_t     hit_beat_o,
  output way_idx_t  victim_way_o,
  output logic      sweep_done_o
);

  // Storage arrays
  logic [NumSets-1:0] valid_q [NumWays];
  tag_t  tag_mem [NumWays][NumSets];
  beat_t data_mem [NumWays][NumSets * (2 ** BeatsWidth)];

  // Read registers of the lookup port
  logic [NumWays-1:0] rd_valid_q;
  tag_t     rd_tag_q [NumWays];
  beat_t    rd_data_q [NumWays];
  tag_t     cmp_tag_q;
  logic     lookup_q;

  set_idx_t  lookup_set;
  beat_idx_t lookup_beat;
  logic [NumWays-1:0] hit_vec;
  way_idx_t  sel_way;
  way_idx_t  rr_q;

  set_idx_t  sweep_idx_q;
  logic      sweep_active_q;
  logic      sweep_done_q;

  assign lookup_set = lookup_addr_i[LineOffsetWidth +: SetsWidth];
  assign lookup_beat = lookup_addr_i[LineOffsetWidth-BeatsWidth +: BeatsWidth];

  ////////////////////
  // Array writes
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_beat_en_i) begin
      data_mem[wr_way_i][{wr_set_i, wr_beat_idx_i}] <= wr_beat_i;
    end
    if (wr_tag_en_i) begin
      tag_mem[wr_way_i][wr_set_i] <= wr_tag_i;
    end
  end

  // Sweep clears one set in all ways, refill sets one valid bit
  always_ff @(posedge clk_i) begin
    if (sweep_active_q) begin
      for (int w = 0; w < NumWays; w++) begin
        valid_q[w][sweep_idx_q] <= 1'b0;
      end
    end else if (wr_tag_en_i) begin
      valid_q[wr_way_i][wr_set_i] <= 1'b1;
    end
  end

  ////////////////////
  // Lookup
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      cmp_tag_q <= lookup_addr_i[PaddrLen-1 -: TagWidth];
      for (int w = 0; w < NumWays; w++) begin
        rd_valid_q[w] <= valid_q[w][lookup_set];
        rd_tag_q[w] <= tag_mem[w][lookup_set];
        rd_data_q[w] <= data_mem[w][{lookup_set, lookup_beat}];
      end
    end
  end

  // Hit way first, then lowest invalid way, then round robin
  always_comb begin
    hit_vec = '0;
    sel_way = rr_q;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!rd_valid_q[w]) begin
        sel_way = way_idx_t'(w);
      end
    end
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (rd_valid_q[w] && rd_tag_q[w] == cmp_tag_q) begin
        hit_vec[w] = 1'b1;
        sel_way = way_idx_t'(w);
      end
    end
  end

  assign hit_o = |hit_vec;
  assign hit_beat_o = rd_data_q[sel_way];
  assign victim_way_o = sel_way;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lookup_q <= 1'b0;
      rr_q <= '0;
      sweep_active_q <= 1'b1;
      sweep_idx_q <= '0;
      sweep_done_q <= 1'b0;
    end else begin
      lookup_q <= lookup_i;
      // Round robin moves on every lookup miss
      if (lookup_q && !hit_o) begin
        rr_q <= rr_q + 1'b1;
      end
      sweep_done_q <= 1'b0;
      if (sweep_start_i) begin
        sweep_active_q <= 1'b1;
        sweep_idx_q <= '0;
      end else if (sweep_active_q) begin
        sweep_idx_q <= sweep_idx_q + 1'b1;
        if (&sweep_idx_q) begin
          sweep_active_q <= 1'b0;
          sweep_done_q <= 1'b1;
        end
      end
    end
  end

  assign sweep_done_o = sweep_done_q;

endmodule

// ==== hdl/icache_pkg.sv ====
// Instruction cache definitions
package icache_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  // Physical byte address
  localparam int unsigned PaddrLen = 32;

  // 4 ways
  localparam int unsigned WaysWidth = 2;
  localparam int unsigned NumWays = 2 ** WaysWidth;

  // 64 sets
  localparam int unsigned SetsWidth = 6;
  localparam int unsigned NumSets = 2 ** SetsWidth;

  // 8 beats of 64 bits make one 64-byte line
  localparam int unsigned BeatsWidth = 3;
  localparam int unsigned LineOffsetWidth = 6;

  // Address bits above the set index
  localparam int unsigned TagWidth = PaddrLen - SetsWidth - LineOffsetWidth;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [PaddrLen-1:0] paddr_t;
  typedef logic [TagWidth-1:0] tag_t;
  typedef logic [SetsWidth-1:0] set_idx_t;
  typedef logic [BeatsWidth-1:0] beat_idx_t;
  typedef logic [WaysWidth-1:0] way_idx_t;
  typedef logic [63:0] beat_t;
  typedef logic [31:0] instr_t;

  typedef enum logic [2:0] {
    FetchIdle,
    FetchLookup,
    FetchFill,
    FetchReplay,
    FetchFault,
    FetchFlush
  } fetch_state_e;

  typedef enum logic [1:0] {
    RefillIdle,
    RefillProgress,
    RefillComplete
  } refill_state_e;

endpackage

// ==== hdl/icache_refill.sv ====
// Instruction cache refill engine
`timescale 1ns/10ps

module icache_refill import icache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      fill_start_i,
  input  paddr_t    fill_addr_i,
  input  way_idx_t  fill_way_i,

  input  logic      mem_beat_valid_i,
  input  beat_t     mem_beat_data_i,
  input  logic      mem_beat_denied_i,

  output logic      wr_beat_en_o,
  output logic      wr_tag_en_o,
  output way_idx_t  wr_way_o,
  output set_idx_t  wr_set_o,
  output beat_idx_t wr_beat_idx_o,
  output beat_t     wr_beat_o,
  output tag_t      wr_tag_o,

  output logic      fill_done_o,
  output logic      fill_denied_o
);

  refill_state_e state_q;
  beat_idx_t     beat_cnt_q;

  // Line being filled
  set_idx_t set_q;
  tag_t     tag_q;
  way_idx_t way_q;
  logic     denied_q;

  logic     beat_take;
  logic     last_beat;

  assign beat_take = state_q == RefillProgress && mem_beat_valid_i;
  assign last_beat = beat_take && &beat_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RefillIdle;
      beat_cnt_q <= '0;
    end else begin
      unique case (state_q)
        RefillIdle: begin
          if (fill_start_i) begin
            beat_cnt_q <= '0;
            state_q <= RefillProgress;
          end
        end
        RefillProgress: begin
          if (beat_take) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
          end
          if (last_beat) begin
            state_q <= RefillComplete;
          end
        end
        default: begin
          state_q <= RefillIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_start_i) begin
      set_q <= fill_addr_i[LineOffsetWidth +: SetsWidth];
      tag_q <= fill_addr_i[PaddrLen-1 -: TagWidth];
      way_q <= fill_way_i;
    end
    if (last_beat) begin
      denied_q <= mem_beat_denied_i;
    end
  end

  // Beats arrive in address order so the count is the beat index
  assign wr_beat_en_o = beat_take && !mem_beat_denied_i;
  assign wr_tag_en_o = last_beat && !mem_beat_denied_i;
  assign wr_way_o = way_q;
  assign wr_set_o = set_q;
  assign wr_beat_idx_o = beat_cnt_q;
  assign wr_beat_o = mem_beat_data_i;
  assign wr_tag_o = tag_q;

  assign fill_done_o = state_q == RefillComplete;
  assign fill_denied_o = denied_q;

endmodule

// ==== hdl/icache_top.sv ====
// Instruction cache top level
`timescale 1ns/10ps

module icache_top import icache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // CPU side
  input  logic     req_valid_i,
  input  logic     req_flush_i,
  input  paddr_t   req_addr_i,
  output logic     resp_valid_o,
  output instr_t   resp_instr_o,
  output logic     resp_fault_o,
  output logic     flush_done_o,

  // Memory side
  output logic     mem_req_valid_o,
  output paddr_t   mem_req_addr_o,
  input  logic     mem_beat_valid_i,
  input  beat_t    mem_beat_data_i,
  input  logic     mem_beat_denied_i
);

  // Front end to line store
  logic      lookup;
  paddr_t    lookup_addr;
  logic      sweep_start;
  logic      hit;
  beat_t     hit_beat;
  way_idx_t  victim_way;
  logic      sweep_done;

  // Front end to refill engine
  logic      fill_start;
  paddr_t    fill_addr;
  way_idx_t  fill_way;
  logic      fill_done;
  logic      fill_denied;

  // Refill engine write port
  logic      wr_beat_en;
  logic      wr_tag_en;
  way_idx_t  wr_way;
  set_idx_t  wr_set;
  beat_idx_t wr_beat_idx;
  beat_t     wr_beat;
  tag_t      wr_tag;

  icache_fetch_ctrl i_fetch_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_flush_i     (req_flush_i),
    .req_addr_i      (req_addr_i),
    .hit_i           (hit),
    .hit_beat_i      (hit_beat),
    .victim_way_i    (victim_way),
    .sweep_done_i    (sweep_done),
    .fill_done_i     (fill_done),
    .fill_denied_i   (fill_denied),
    .resp_valid_o    (resp_valid_o),
    .resp_instr_o    (resp_instr_o),
    .resp_fault_o    (resp_fault_o),
    .flush_done_o    (flush_done_o),
    .lookup_o        (lookup),
    .lookup_addr_o   (lookup_addr),
    .sweep_start_o   (sweep_start),
    .fill_start_o    (fill_start),
    .fill_addr_o     (fill_addr),
    .fill_way_o      (fill_way),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o)
  );

  icache_line_store i_line_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_i      (lookup),
    .lookup_addr_i (lookup_addr),
    .sweep_start_i (sweep_start),
    .wr_beat_en_i  (wr_beat_en),
    .wr_tag_en_i   (wr_tag_en),
    .wr_way_i      (wr_way),
    .wr_set_i      (wr_set),
    .wr_beat_idx_i (wr_beat_idx),
    .wr_beat_i     (wr_beat),
    .wr_tag_i      (wr_tag),
    .hit_o         (hit),
    .hit_beat_o    (hit_beat),
    .victim_way_o  (victim_way),
    .sweep_done_o  (sweep_done)
  );

  icache_refill i_refill (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fill_start_i      (fill_start),
    .fill_addr_i       (fill_addr),
    .fill_way_i        (fill_way),
    .mem_beat_valid_i  (mem_beat_valid_i),
    .mem_beat_data_i   (mem_beat_data_i),
    .mem_beat_denied_i (mem_beat_denied_i),
    .wr_beat_en_o      (wr_beat_en),
    .wr_tag_en_o       (wr_tag_en),
    .wr_way_o          (wr_way),
    .wr_set_o          (wr_set),
    .wr_beat_idx_o     (wr_beat_idx),
    .wr_beat_o         (wr_beat),
    .wr_tag_o          (wr_tag),
    .fill_done_o       (fill_done),
    .fill_denied_o     (fill_denied)
  );

endmodule

// ==== verilog.f ====
hdl/icache_pkg.sv
hdl/icache_refill.sv
hdl/icache_line_store.sv
hdl/icache_fetch_ctrl.sv
hdl/icache_top.sv
bench/icache_chk.sv
bench/icache_tb.sv
